//--- design/isa_pkg.sv
package isa_pkg;

    localparam int SHAMT_W = 5;
    localparam int IMM_W   = 16;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcodes, SPECIAL selects the funct field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_NOP
    } alu_op_e;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    // one extra bit so a full queue can be counted
    localparam int CNT_W      = PTR_W + 1;

    localparam int NUM_SLOTS  = 2;

    localparam logic [31:0] RESET_PC = 32'hbfc0_0000;
    localparam logic [31:0] PC_STEP  = 32'd4;

endpackage

//--- design/pipe_if.sv
`timescale 1ns/100ps

// one issued instruction, issue register to execute
interface issue_slot_if import isa_pkg::*; ();
    logic      valid;
    word_t     pc;
    alu_op_e   alu_op;
    word_t     opa;
    word_t     opb;
    logic      wen;
    reg_addr_t waddr;

    modport sender   (output valid, pc, alu_op, opa, opb, wen, waddr);
    modport receiver (input  valid, pc, alu_op, opa, opb, wen, waddr);
endinterface

// result of one slot in execute or writeback
interface result_if import isa_pkg::*; ();
    logic      valid;
    word_t     pc;
    logic      wen;
    reg_addr_t waddr;
    word_t     wdata;

    modport sender   (output valid, pc, wen, waddr, wdata);
    modport receiver (input  valid, pc, wen, waddr, wdata);
endinterface

//--- design/inst_fifo.sv
`timescale 1ns/100ps

module inst_fifo import isa_pkg::*; import pipe_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             wr_en1_i,
    input  logic             wr_en2_i,
    input  word_t            wr_data1_i,
    input  word_t            wr_data2_i,
    input  logic             rd_en1_i,
    input  logic             rd_en2_i,
    output word_t            rd_data1_o,
    output word_t            rd_data2_o,
    output word_t            rd_pc1_o,
    output word_t            rd_pc2_o,
    output logic [CNT_W-1:0] count_o,
    output logic             full_o
);

    word_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count_q;
    word_t             pc_q;
    logic              wr_ok;
    logic [1:0]        push_num;
    logic [1:0]        pop_num;

    // words offered while full are dropped
    assign wr_ok    = wr_en1_i && !full_o;
    assign push_num = wr_ok ? (wr_en2_i ? 2'd2 : 2'd1) : 2'd0;
    assign pop_num  = rd_en1_i ? (rd_en2_i ? 2'd2 : 2'd1) : 2'd0;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data1_i;
            if (wr_en2_i)
                mem[wr_ptr + PTR_W'(1)] <= wr_data2_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            pc_q    <= RESET_PC;
        end else begin
            wr_ptr  <= wr_ptr + PTR_W'(push_num);
            rd_ptr  <= rd_ptr + PTR_W'(pop_num);
            count_q <= count_q + CNT_W'(push_num) - CNT_W'(pop_num);
            // head pc follows the released words
            case (pop_num)
                2'd1:    pc_q <= pc_q + PC_STEP;
                2'd2:    pc_q <= pc_q + (PC_STEP << 1);
                default: pc_q <= pc_q;
            endcase
        end
    end

    assign rd_data1_o = mem[rd_ptr];
    assign rd_data2_o = mem[rd_ptr + PTR_W'(1)];
    assign rd_pc1_o   = pc_q;
    assign rd_pc2_o   = pc_q + PC_STEP;
    assign count_o    = count_q;
    // fewer than two free entries
    assign full_o     = count_q > CNT_W'(FIFO_DEPTH - 2);

endmodule

//--- design/decoder.sv
`timescale 1ns/100ps

module decoder import isa_pkg::*; (
    input  word_t              inst_i,
    output alu_op_e            alu_op_o,
    output reg_addr_t          rs_o,
    output reg_addr_t          rt_o,
    output logic               use_shamt_o,
    output logic               use_imm_o,
    output word_t              imm_o,
    output logic [SHAMT_W-1:0] shamt_o,
    output logic               wen_o,
    output reg_addr_t          waddr_o
);

    opcode_e          opcode;
    funct_e           funct;
    logic [IMM_W-1:0] imm_field;
    logic             sign_ext;

    assign opcode    = opcode_e'(inst_i[31:26]);
    assign funct     = funct_e'(inst_i[5:0]);
    assign imm_field = inst_i[IMM_W-1:0];
    assign rs_o      = inst_i[25:21];
    assign rt_o      = inst_i[20:16];
    assign shamt_o   = inst_i[10:6];

    // arithmetic and compare immediates are sign extended
    assign sign_ext = (opcode == OP_ADDIU) || (opcode == OP_SLTI) || (opcode == OP_SLTIU);
    assign imm_o    = {{($bits(word_t) - IMM_W){sign_ext & imm_field[IMM_W-1]}}, imm_field};

    always_comb begin
        alu_op_o    = ALU_NOP;
        use_shamt_o = 1'b0;
        use_imm_o   = 1'b1;
        wen_o       = 1'b1;
        waddr_o     = inst_i[20:16];
        case (opcode)
            OP_SPECIAL: begin
                use_imm_o = 1'b0;
                waddr_o   = inst_i[15:11];
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_NOR:  alu_op_o = ALU_NOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    FN_SLTU: alu_op_o = ALU_SLTU;
                    FN_SLL: begin
                        alu_op_o    = ALU_SLL;
                        use_shamt_o = 1'b1;
                    end
                    FN_SRL: begin
                        alu_op_o    = ALU_SRL;
                        use_shamt_o = 1'b1;
                    end
                    FN_SRA: begin
                        alu_op_o    = ALU_SRA;
                        use_shamt_o = 1'b1;
                    end
                    default: wen_o = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op_o = ALU_ADD;
            OP_SLTI:  alu_op_o = ALU_SLT;
            OP_SLTIU: alu_op_o = ALU_SLTU;
            OP_ANDI:  alu_op_o = ALU_AND;
            OP_ORI:   alu_op_o = ALU_OR;
            OP_XORI:  alu_op_o = ALU_XOR;
            OP_LUI:   alu_op_o = ALU_LUI;
            // undefined word retires without a write
            default:  wen_o = 1'b0;
        endcase
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/100ps

module regfile import isa_pkg::*; import pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  reg_addr_t  raddr_i [2*NUM_SLOTS],
    output word_t      rdata_o [2*NUM_SLOTS],
    result_if.receiver wb0,
    result_if.receiver wb1
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else begin
            if (wb0.valid && wb0.wen && wb0.waddr != '0)
                regs[wb0.waddr] <= wb0.wdata;
            // slot 1 is younger and wins on a shared target
            if (wb1.valid && wb1.wen && wb1.waddr != '0)
                regs[wb1.waddr] <= wb1.wdata;
        end
    end

    // r0 is cleared on reset and never written
    always_comb begin
        for (int i = 0; i < 2*NUM_SLOTS; i++)
            rdata_o[i] = regs[raddr_i[i]];
    end

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

module alu import isa_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   y_o
);

    logic [SHAMT_W-1:0] sa;

    // shift amount always comes in on operand a
    assign sa = a_i[SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_NOR:  y_o = ~(a_i | b_i);
            ALU_SLT:  y_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: y_o = word_t'(a_i < b_i);
            ALU_SLL:  y_o = b_i << sa;
            ALU_SRL:  y_o = b_i >> sa;
            ALU_SRA:  y_o = word_t'($signed(b_i) >>> sa);
            ALU_LUI:  y_o = b_i << IMM_W;
            default:  y_o = '0;
        endcase
    end

endmodule

//--- design/issue_stage.sv
`timescale 1ns/100ps

module issue_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,
    input  word_t            head1_i,
    input  word_t            head2_i,
    input  word_t            pc1_i,
    input  word_t            pc2_i,
    input  logic [CNT_W-1:0] count_i,
    output logic             pop1_o,
    output logic             pop2_o,
    output reg_addr_t        raddr_o [2*NUM_SLOTS],
    input  word_t            rdata_i [2*NUM_SLOTS],
    result_if.receiver       ex0,
    result_if.receiver       ex1,
    result_if.receiver       wb0,
    result_if.receiver       wb1,
    issue_slot_if.sender     slot0,
    issue_slot_if.sender     slot1
);

    alu_op_e            m_alu_op,    s_alu_op;
    reg_addr_t          m_rs,        s_rs;
    reg_addr_t          m_rt,        s_rt;
    logic               m_use_shamt, s_use_shamt;
    logic               m_use_imm,   s_use_imm;
    word_t              m_imm,       s_imm;
    logic [SHAMT_W-1:0] m_shamt,     s_shamt;
    logic               m_wen,       s_wen;
    reg_addr_t          m_waddr,     s_waddr;
    word_t              fwd_data [2*NUM_SLOTS];
    word_t              m_opa,       m_opb;
    word_t              s_opa,       s_opb;
    logic               s_dep;

    decoder u_dec_master (
        .inst_i      (head1_i),
        .alu_op_o    (m_alu_op),
        .rs_o        (m_rs),
        .rt_o        (m_rt),
        .use_shamt_o (m_use_shamt),
        .use_imm_o   (m_use_imm),
        .imm_o       (m_imm),
        .shamt_o     (m_shamt),
        .wen_o       (m_wen),
        .waddr_o     (m_waddr)
    );

    decoder u_dec_slave (
        .inst_i      (head2_i),
        .alu_op_o    (s_alu_op),
        .rs_o        (s_rs),
        .rt_o        (s_rt),
        .use_shamt_o (s_use_shamt),
        .use_imm_o   (s_use_imm),
        .imm_o       (s_imm),
        .shamt_o     (s_shamt),
        .wen_o       (s_wen),
        .waddr_o     (s_waddr)
    );

    assign raddr_o[0] = m_rs;
    assign raddr_o[1] = m_rt;
    assign raddr_o[2] = s_rs;
    assign raddr_o[3] = s_rt;

    // later checks override earlier ones, so ex1 is the youngest source
    always_comb begin
        for (int i = 0; i < 2*NUM_SLOTS; i++) begin
            fwd_data[i] = rdata_i[i];
            if (raddr_o[i] != '0) begin
                if (wb0.valid && wb0.wen && wb0.waddr == raddr_o[i])
                    fwd_data[i] = wb0.wdata;
                if (wb1.valid && wb1.wen && wb1.waddr == raddr_o[i])
                    fwd_data[i] = wb1.wdata;
                if (ex0.valid && ex0.wen && ex0.waddr == raddr_o[i])
                    fwd_data[i] = ex0.wdata;
                if (ex1.valid && ex1.wen && ex1.waddr == raddr_o[i])
                    fwd_data[i] = ex1.wdata;
            end
        end
    end

    assign m_opa = m_use_shamt ? word_t'(m_shamt) : fwd_data[0];
    assign m_opb = m_use_imm   ? m_imm            : fwd_data[1];
    assign s_opa = s_use_shamt ? word_t'(s_shamt) : fwd_data[2];
    assign s_opb = s_use_imm   ? s_imm            : fwd_data[3];

    // slave waits if it reads what the master writes
    assign s_dep  = m_wen && (m_waddr != '0) && ((s_rs == m_waddr) || (s_rt == m_waddr));
    assign pop1_o = count_i != '0;
    assign pop2_o = (count_i >= CNT_W'(NUM_SLOTS)) && !s_dep;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot0.valid <= 1'b0;
            slot1.valid <= 1'b0;
        end else begin
            slot0.valid <= pop1_o;
            slot1.valid <= pop2_o;
        end
    end

    always_ff @(posedge clk) begin
        slot0.pc     <= pc1_i;
        slot0.alu_op <= m_alu_op;
        slot0.opa    <= m_opa;
        slot0.opb    <= m_opb;
        slot0.wen    <= m_wen;
        slot0.waddr  <= m_waddr;
        slot1.pc     <= pc2_i;
        slot1.alu_op <= s_alu_op;
        slot1.opa    <= s_opa;
        slot1.opb    <= s_opb;
        slot1.wen    <= s_wen;
        slot1.waddr  <= s_waddr;
    end

endmodule

//--- design/exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
    input  logic           clk,
    input  logic           reset_i,
    issue_slot_if.receiver slot0,
    issue_slot_if.receiver slot1,
    result_if.sender       ex0,
    result_if.sender       ex1,
    result_if.sender       wb0,
    result_if.sender       wb1
);

    alu u_alu0 (
        .op_i (slot0.alu_op),
        .a_i  (slot0.opa),
        .b_i  (slot0.opb),
        .y_o  (ex0.wdata)
    );

    alu u_alu1 (
        .op_i (slot1.alu_op),
        .a_i  (slot1.opa),
        .b_i  (slot1.opb),
        .y_o  (ex1.wdata)
    );

    assign ex0.valid = slot0.valid;
    assign ex0.pc    = slot0.pc;
    assign ex0.wen   = slot0.wen;
    assign ex0.waddr = slot0.waddr;
    assign ex1.valid = slot1.valid;
    assign ex1.pc    = slot1.pc;
    assign ex1.wen   = slot1.wen;
    assign ex1.waddr = slot1.waddr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb0.valid <= 1'b0;
            wb1.valid <= 1'b0;
        end else begin
            wb0.valid <= ex0.valid;
            wb1.valid <= ex1.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb0.pc    <= ex0.pc;
        wb0.wen   <= ex0.wen;
        wb0.waddr <= ex0.waddr;
        wb0.wdata <= ex0.wdata;
        wb1.pc    <= ex1.pc;
        wb1.wen   <= ex1.wen;
        wb1.waddr <= ex1.waddr;
        wb1.wdata <= ex1.wdata;
    end

endmodule

//--- design/dual_issue_core.sv
`timescale 1ns/100ps

module dual_issue_core import isa_pkg::*; import pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_ok1_i,
    input  logic      inst_ok2_i,
    input  word_t     inst_rdata1_i,
    input  word_t     inst_rdata2_i,
    output logic      fifo_full_o,
    output logic      wb0_valid_o,
    output logic      wb1_valid_o,
    output word_t     wb0_pc_o,
    output word_t     wb1_pc_o,
    output logic      wb0_wen_o,
    output logic      wb1_wen_o,
    output reg_addr_t wb0_wnum_o,
    output reg_addr_t wb1_wnum_o,
    output word_t     wb0_wdata_o,
    output word_t     wb1_wdata_o
);

    word_t            head1, head2;
    word_t            pc1, pc2;
    logic [CNT_W-1:0] fifo_count;
    logic             pop1, pop2;
    reg_addr_t        rf_raddr [2*NUM_SLOTS];
    word_t            rf_rdata [2*NUM_SLOTS];

    issue_slot_if slot0_if ();
    issue_slot_if slot1_if ();
    result_if     ex0_if ();
    result_if     ex1_if ();
    result_if     wb0_if ();
    result_if     wb1_if ();

    inst_fifo u_inst_fifo (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en1_i   (inst_ok1_i),
        .wr_en2_i   (inst_ok2_i),
        .wr_data1_i (inst_rdata1_i),
        .wr_data2_i (inst_rdata2_i),
        .rd_en1_i   (pop1),
        .rd_en2_i   (pop2),
        .rd_data1_o (head1),
        .rd_data2_o (head2),
        .rd_pc1_o   (pc1),
        .rd_pc2_o   (pc2),
        .count_o    (fifo_count),
        .full_o     (fifo_full_o)
    );

    issue_stage u_issue_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .head1_i (head1),
        .head2_i (head2),
        .pc1_i   (pc1),
        .pc2_i   (pc2),
        .count_i (fifo_count),
        .pop1_o  (pop1),
        .pop2_o  (pop2),
        .raddr_o (rf_raddr),
        .rdata_i (rf_rdata),
        .ex0     (ex0_if.receiver),
        .ex1     (ex1_if.receiver),
        .wb0     (wb0_if.receiver),
        .wb1     (wb1_if.receiver),
        .slot0   (slot0_if.sender),
        .slot1   (slot1_if.sender)
    );

    exec_stage u_exec_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .slot0   (slot0_if.receiver),
        .slot1   (slot1_if.receiver),
        .ex0     (ex0_if.sender),
        .ex1     (ex1_if.sender),
        .wb0     (wb0_if.sender),
        .wb1     (wb1_if.sender)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .wb0     (wb0_if.receiver),
        .wb1     (wb1_if.receiver)
    );

    // retire report straight from the writeback register
    assign wb0_valid_o = wb0_if.valid;
    assign wb0_pc_o    = wb0_if.pc;
    assign wb0_wen_o   = wb0_if.wen;
    assign wb0_wnum_o  = wb0_if.waddr;
    assign wb0_wdata_o = wb0_if.wdata;
    assign wb1_valid_o = wb1_if.valid;
    assign wb1_pc_o    = wb1_if.pc;
    assign wb1_wen_o   = wb1_if.wen;
    assign wb1_wnum_o  = wb1_if.waddr;
    assign wb1_wdata_o = wb1_if.wdata;

endmodule

//--- dv/tb_core.sv
`timescale 1ns/100ps

module tb_core import isa_pkg::*; import pipe_pkg::*; ();

    localparam logic [31:0] SEED        = 32'h6de3_a434;
    localparam int          NUM_INST    = 600;
    localparam int          STALL_LIMIT = 50;
    localparam int          DRAIN_LIMIT = 200;

    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } exp_t;

    logic        clk;
    logic        reset_i;
    logic        inst_ok1_i, inst_ok2_i;
    word_t       inst_rdata1_i, inst_rdata2_i;
    logic        fifo_full_o;
    logic        wb0_valid_o, wb1_valid_o;
    word_t       wb0_pc_o, wb1_pc_o;
    logic        wb0_wen_o, wb1_wen_o;
    reg_addr_t   wb0_wnum_o, wb1_wnum_o;
    word_t       wb0_wdata_o, wb1_wdata_o;

    word_t       model_regs [32];
    exp_t        exp_q [$];
    logic [31:0] rng;
    int          value_errs;
    int          other_errs;
    int          written;
    int          retired;
    bit          full_seen;
    bit          timed_out;

    dual_issue_core i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_ok1_i    (inst_ok1_i),
        .inst_ok2_i    (inst_ok2_i),
        .inst_rdata1_i (inst_rdata1_i),
        .inst_rdata2_i (inst_rdata2_i),
        .fifo_full_o   (fifo_full_o),
        .wb0_valid_o   (wb0_valid_o),
        .wb1_valid_o   (wb1_valid_o),
        .wb0_pc_o      (wb0_pc_o),
        .wb1_pc_o      (wb1_pc_o),
        .wb0_wen_o     (wb0_wen_o),
        .wb1_wen_o     (wb1_wen_o),
        .wb0_wnum_o    (wb0_wnum_o),
        .wb1_wnum_o    (wb1_wnum_o),
        .wb0_wdata_o   (wb0_wdata_o),
        .wb1_wdata_o   (wb1_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // chain mode reads and writes r1 only, so pairs rarely dual issue
    function automatic word_t gen_inst(input bit chain);
        logic [31:0] r;
        reg_addr_t   rs, rt, rd;
        logic [4:0]  kind;
        word_t       w;
        r    = rand_word();
        rs   = chain ? 5'd1 : {2'b00, r[2:0]};
        rt   = chain ? 5'd1 : {2'b00, r[5:3]};
        rd   = chain ? 5'd1 : {2'b00, r[8:6]};
        kind = r[13:9] % 5'd20;
        case (kind)
            5'd0:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
            5'd1:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
            5'd2:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
            5'd3:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
            5'd4:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
            5'd5:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_NOR};
            5'd6:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
            5'd7:    w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLTU};
            5'd8:    w = {OP_SPECIAL, 5'd0, rt, rd, r[18:14], FN_SLL};
            5'd9:    w = {OP_SPECIAL, 5'd0, rt, rd, r[18:14], FN_SRL};
            5'd10:   w = {OP_SPECIAL, 5'd0, rt, rd, r[18:14], FN_SRA};
            5'd11:   w = {OP_ADDIU, rs, rt, r[31:16]};
            5'd12:   w = {OP_SLTI, rs, rt, r[31:16]};
            5'd13:   w = {OP_SLTIU, rs, rt, r[31:16]};
            5'd14:   w = {OP_ANDI, rs, rt, r[31:16]};
            5'd15:   w = {OP_ORI, rs, rt, r[31:16]};
            5'd16:   w = {OP_XORI, rs, rt, r[31:16]};
            5'd17:   w = {OP_LUI, 5'd0, rt, r[31:16]};
            // unknown primary opcode or unknown funct
            5'd18:   w = {6'h3f, r[25:0]};
            default: w = {OP_SPECIAL, rs, rt, rd, 5'd0, 6'h3f};
        endcase
        return w;
    endfunction

    // executes one word on the model registers in program order
    function automatic exp_t ref_exec(input word_t inst, input word_t pc);
        exp_t       e;
        opcode_e    op;
        funct_e     fn;
        word_t      a, b, imm_s, imm_z;
        logic [4:0] sa;
        op      = opcode_e'(inst[31:26]);
        fn      = funct_e'(inst[5:0]);
        sa      = inst[10:6];
        a       = model_regs[inst[25:21]];
        b       = model_regs[inst[20:16]];
        imm_s   = {{16{inst[15]}}, inst[15:0]};
        imm_z   = {16'h0000, inst[15:0]};
        e.pc    = pc;
        e.wen   = 1'b1;
        e.wnum  = inst[20:16];
        e.wdata = '0;
        if (op == OP_SPECIAL) begin
            e.wnum = inst[15:11];
            case (fn)
                FN_ADDU: e.wdata = a + b;
                FN_SUBU: e.wdata = a - b;
                FN_AND:  e.wdata = a & b;
                FN_OR:   e.wdata = a | b;
                FN_XOR:  e.wdata = a ^ b;
                FN_NOR:  e.wdata = ~(a | b);
                FN_SLT:  e.wdata = {31'd0, $signed(a) < $signed(b)};
                FN_SLTU: e.wdata = {31'd0, a < b};
                FN_SLL:  e.wdata = b << sa;
                FN_SRL:  e.wdata = b >> sa;
                FN_SRA:  e.wdata = $signed(b) >>> sa;
                default: e.wen = 1'b0;
            endcase
        end else begin
            case (op)
                OP_ADDIU: e.wdata = a + imm_s;
                OP_SLTI:  e.wdata = {31'd0, $signed(a) < $signed(imm_s)};
                OP_SLTIU: e.wdata = {31'd0, a < imm_s};
                OP_ANDI:  e.wdata = a & imm_z;
                OP_ORI:   e.wdata = a | imm_z;
                OP_XORI:  e.wdata = a ^ imm_z;
                OP_LUI:   e.wdata = {inst[15:0], 16'h0000};
                default:  e.wen = 1'b0;
            endcase
        end
        // r0 keeps reading zero
        if (e.wen && e.wnum != 5'd0)
            model_regs[e.wnum] = e.wdata;
        return e;
    endfunction

    task automatic check_retire(input int slot, input word_t pc, input logic wen,
                                input reg_addr_t wnum, input word_t wdata);
        exp_t e;
        retired++;
        assert (exp_q.size() != 0) else begin
            $display("slot %0d retired pc %08h with nothing outstanding", slot, pc);
            other_errs++;
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (pc == e.pc) else begin
                $display("ERR wb%0d_pc_o exp=%08h got=%08h", slot, e.pc, pc);
                value_errs++;
            end
            assert (wen == e.wen) else begin
                $display("ERR wb%0d_wen_o pc=%08h exp=%0h got=%0h", slot, e.pc, e.wen, wen);
                value_errs++;
            end
            if (e.wen) begin
                assert (wnum == e.wnum) else begin
                    $display("ERR wb%0d_wnum_o pc=%08h exp=%02h got=%02h",
                             slot, e.pc, e.wnum, wnum);
                    value_errs++;
                end
                assert (wdata == e.wdata) else begin
                    $display("ERR wb%0d_wdata_o pc=%08h exp=%08h got=%08h",
                             slot, e.pc, e.wdata, wdata);
                    value_errs++;
                end
            end
        end
    endtask

    // retire compare with slot 0 as the older one
    always @(posedge clk) begin
        if (!reset_i) begin
            if (fifo_full_o)
                full_seen = 1'b1;
            assert (!(wb1_valid_o && !wb0_valid_o)) else begin
                $display("slot 1 retired pc %08h without a slot 0 retirement", wb1_pc_o);
                other_errs++;
            end
            if (wb0_valid_o)
                check_retire(0, wb0_pc_o, wb0_wen_o, wb0_wnum_o, wb0_wdata_o);
            if (wb1_valid_o)
                check_retire(1, wb1_pc_o, wb1_wen_o, wb1_wnum_o, wb1_wdata_o);
        end
    end

    initial begin
        int    bound;
        int    pend;
        int    want;
        int    n;
        int    idle;
        int    wait_cnt;
        bit    chain;
        word_t w;
        reset_i       = 1'b1;
        inst_ok1_i    = 1'b0;
        inst_ok2_i    = 1'b0;
        inst_rdata1_i = '0;
        inst_rdata2_i = '0;
        value_errs    = 0;
        other_errs    = 0;
        written       = 0;
        retired       = 0;
        full_seen     = 1'b0;
        timed_out     = 1'b0;
        rng           = SEED;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;

        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        // nothing may come out before words arrive
        repeat (4) begin
            @(posedge clk);
            assert (!fifo_full_o && !wb0_valid_o && !wb1_valid_o) else begin
                $display("full or retire valid active after reset with no words written");
                other_errs++;
            end
        end

        bound = 0;
        pend  = 0;
        idle  = 0;
        while (written < NUM_INST && !timed_out) begin
            @(posedge clk);
            // upper bound on queue fill since the master drains a word each busy cycle
            if (!fifo_full_o && bound > FIFO_DEPTH - 2)
                bound = FIFO_DEPTH - 2;
            bound = (bound == 0) ? pend : bound + pend - 1;
            chain = (written >= 200 && written < 360);
            want  = (chain || written >= 480) ? 2 : rand_word() % 3;
            n     = 0;
            if (!fifo_full_o && bound <= FIFO_DEPTH - 2)
                n = (want > NUM_INST - written) ? NUM_INST - written : want;
            inst_ok1_i <= 1'b0;
            inst_ok2_i <= 1'b0;
            if (n > 0) begin
                w = gen_inst(chain);
                exp_q.push_back(ref_exec(w, RESET_PC + PC_STEP * written));
                inst_ok1_i    <= 1'b1;
                inst_rdata1_i <= w;
            end
            if (n > 1) begin
                w = gen_inst(chain);
                exp_q.push_back(ref_exec(w, RESET_PC + PC_STEP * (written + 1)));
                inst_ok2_i    <= 1'b1;
                inst_rdata2_i <= w;
            end
            written = written + n;
            pend    = n;
            if (n > 0)
                idle = 0;
            else
                idle++;
            if (idle > STALL_LIMIT) begin
                $display("timeout: no word sent for %0d cycles with %0d words left to send",
                         idle, NUM_INST - written);
                other_errs++;
                timed_out = 1'b1;
            end
        end
        @(posedge clk);
        inst_ok1_i <= 1'b0;
        inst_ok2_i <= 1'b0;

        wait_cnt = 0;
        while (!timed_out && exp_q.size() != 0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > DRAIN_LIMIT) begin
                $display("timeout: %0d instructions never retired", exp_q.size());
                other_errs++;
                timed_out = 1'b1;
            end
        end
        // catch stray retirements
        repeat (4) @(posedge clk);

        assert (retired == written) else begin
            $display("retired %0d instructions but %0d were written", retired, written);
            other_errs++;
        end
        assert (full_seen) else begin
            $display("fifo_full_o never went high during the two-word bursts");
            other_errs++;
        end

        $display("errors: %0d value, %0d other; %0d of %0d words retired",
                 value_errs, other_errs, retired, written);
        if (value_errs == 0 && other_errs == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- sources.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_if.sv
design/inst_fifo.sv
design/decoder.sv
design/regfile.sv
design/alu.sv
design/issue_stage.sv
design/exec_stage.sv
design/dual_issue_core.sv
dv/tb_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_core
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
